//--- project.f
+incdir+hdl
+incdir+bench
hdl/rewardPkg.sv
hdl/rewardTrigger.sv
hdl/packetQueue.sv
hdl/txStage.sv
hdl/rewardTop.sv
bench/tbReward.sv

//--- bench/rewardModel.svh
`ifndef REWARD_MODEL_SVH
`define REWARD_MODEL_SVH

    // model state, mirrors heartbeat lock and idle countdown
    logic                   modelLock  = 1'b0;
    logic [`WORD_WIDTH-1:0] modelCount = `TIMEOUT_RELOAD;
    // fibonacci lfsr, taps 32 22 2 1
    logic [31:0]            lfsrState  = 32'ha5e9;

    function automatic logic lfsrBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [`WORD_WIDTH-1:0] randomWord();
        logic [`WORD_WIDTH-1:0] word;
        word = '0;
        for (int i = 0; i < `WORD_WIDTH; i++) begin
            word = {word[`WORD_WIDTH-2:0], lfsrBit()};
        end
        return word;
    endfunction

    // expected packet for the inputs seen at this edge
    // returns 1 when a packet gets built
    function automatic logic predictPacket(output rewardPacket_t want);
        logic built;
        logic lockWas;
        logic expired;
        built   = 1'b0;
        lockWas = modelLock;
        expired = (modelCount == 0);
        // own node fields by default
        want.pktType       = DATA;
        want.sourceId      = myNodeId;
        want.sourceHops    = hopsFromSink;
        want.qValue        = myQValue;
        want.energyLeft    = myEnergy;
        want.destinationId = chosenHop;
        want.chosenCh      = chosenCh;
        want.hopsFromCh    = hopsFromCh;
        want.timeslot      = timeslot;
        if (en) begin
            // received fields, timeslot stays the local one
            want.pktType    = fPacketType;
            want.sourceId   = fSourceId;
            want.sourceHops = fSourceHops;
            want.qValue     = fQValue;
            want.energyLeft = fEnergyLeft;
            want.chosenCh   = fChosenCh;
            want.hopsFromCh = fHopsFromCh;
            if (fPacketType == HB && !lockWas) begin
                built              = 1'b1;
                want.sourceHops    = hopsFromSink + 1;
                want.destinationId = `BROADCAST_ID;
                modelLock          = 1'b1;
            end else if (fPacketType == INV && fHopsFromCh < `MAX_INV_HOPS) begin
                built              = 1'b1;
                want.hopsFromCh    = fHopsFromCh + 1;
                want.destinationId = `BROADCAST_ID;
            end else if ((fPacketType == DATA || fPacketType == SOS) && iAmDestination) begin
                built = 1'b1;
                // forwarded data reopens heartbeat ripple
                if (fPacketType == DATA) begin
                    modelLock = 1'b0;
                end
            end
        end else if (iHaveData) begin
            built        = 1'b1;
            want.pktType = lowE ? SOS : DATA;
            if (hopsFromSink == 1) begin
                want.chosenCh = '0;
            end
        end else if (expired) begin
            built = 1'b1;
            if (role) begin
                want.pktType       = CHT;
                want.destinationId = `BROADCAST_ID;
            end else begin
                want.pktType       = MR;
                want.destinationId = chosenCh;
            end
        end
        // countdown only runs while locked
        if (en || iHaveData || expired) begin
            modelCount = `TIMEOUT_RELOAD;
        end else if (lockWas) begin
            modelCount = modelCount - 1;
        end
        return built;
    endfunction

`endif

//--- bench/tbReward.sv
`timescale 1ns/1ps
`default_nettype none

`include "reward_defs.svh"

module tbReward;

    import rewardPkg::*;

    localparam int clkPeriod = 8;
    // events issued below for the watchdog budget
    localparam int numEvents = 21;
    // hold register plus queue entries
    localparam int capacity  = `QUEUE_DEPTH + 1;

    logic clk;
    logic nrst;
    // event strobes and node status
    logic en;
    logic iHaveData;
    logic iAmDestination;
    logic role;
    logic lowE;
    logic okToSend;
    // received packet
    pktType_e fPacketType;
    logic [`WORD_WIDTH-1:0] fSourceId;
    logic [`WORD_WIDTH-1:0] fSourceHops;
    logic [`WORD_WIDTH-1:0] fQValue;
    logic [`WORD_WIDTH-1:0] fEnergyLeft;
    logic [`WORD_WIDTH-1:0] fHopsFromCh;
    logic [`WORD_WIDTH-1:0] fChosenCh;
    // own node state
    logic [`WORD_WIDTH-1:0] myNodeId;
    logic [`WORD_WIDTH-1:0] myEnergy;
    logic [`WORD_WIDTH-1:0] myQValue;
    logic [`WORD_WIDTH-1:0] hopsFromSink;
    logic [`WORD_WIDTH-1:0] hopsFromCh;
    logic [`WORD_WIDTH-1:0] chosenCh;
    logic [`WORD_WIDTH-1:0] chosenHop;
    logic [`WORD_WIDTH-1:0] timeslot;
    // radio side
    logic txValid;
    logic txSetting;
    logic rewardDone;
    logic overflow;
    pktType_e rPacketType;
    logic [`WORD_WIDTH-1:0] rSourceId;
    logic [`WORD_WIDTH-1:0] rSourceHops;
    logic [`WORD_WIDTH-1:0] rQValue;
    logic [`WORD_WIDTH-1:0] rEnergyLeft;
    logic [`WORD_WIDTH-1:0] rDestinationId;
    logic [`WORD_WIDTH-1:0] rChosenCh;
    logic [`WORD_WIDTH-1:0] rHopsFromCh;
    logic [`WORD_WIDTH-1:0] rTimeslot;

    // expected packets with the oldest first
    rewardPacket_t expected[$];
    logic          doneDue     = 1'b0;
    logic          expOverflow = 1'b0;
    int            acceptCount = 0;
    pktType_e      lastType    = NONE;

    `include "rewardModel.svh"

    rewardTop dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compareField(input string name, input logic [`WORD_WIDTH-1:0] actual,
                                input logic [`WORD_WIDTH-1:0] want);
        assert (actual === want) else begin
            abortRun($sformatf("FAILED %s expected 0x%h actual 0x%h", name, want, actual));
        end
    endtask

    // compare at each acceptance then step the model
    always @(posedge clk) begin : compare
        rewardPacket_t want;
        rewardPacket_t next;
        if (nrst) begin
            // done exactly one cycle after acceptance
            compareField("rewardDone", rewardDone, doneDue);
            doneDue = 1'b0;
            if (txValid === 1'b1 && okToSend === 1'b1) begin
                assert (expected.size() != 0) else begin
                    abortRun("the radio was offered a packet that no event should have built");
                end
                want = expected.pop_front();
                compareField("rPacketType", rPacketType, want.pktType);
                compareField("rSourceId", rSourceId, want.sourceId);
                compareField("rSourceHops", rSourceHops, want.sourceHops);
                compareField("rQValue", rQValue, want.qValue);
                compareField("rEnergyLeft", rEnergyLeft, want.energyLeft);
                compareField("rDestinationId", rDestinationId, want.destinationId);
                compareField("rChosenCh", rChosenCh, want.chosenCh);
                compareField("rHopsFromCh", rHopsFromCh, want.hopsFromCh);
                compareField("rTimeslot", rTimeslot, want.timeslot);
                // four-hop only for MR to a distant head
                compareField("txSetting", txSetting, want.pktType == MR && want.hopsFromCh > 1);
                lastType = want.pktType;
                acceptCount++;
                doneDue = 1'b1;
            end
            if (predictPacket(next)) begin
                // hold and queue both full so the packet is lost
                if (expected.size() == capacity) begin
                    expOverflow = 1'b1;
                end else begin
                    expected.push_back(next);
                end
            end
        end
    end

    // one cycle en pulse carrying a received packet
    task automatic receive(input pktType_e kind, input logic [`WORD_WIDTH-1:0] hops,
                           input logic addressed);
        @(posedge clk);
        #1;
        fPacketType    = kind;
        fSourceId      = randomWord();
        fSourceHops    = randomWord();
        fQValue        = randomWord();
        fEnergyLeft    = randomWord();
        fChosenCh      = randomWord();
        fHopsFromCh    = hops;
        iAmDestination = addressed;
        timeslot       = randomWord();
        en             = 1'b1;
        @(posedge clk);
        #1;
        en = 1'b0;
    endtask

    task automatic ownData(input logic low);
        @(posedge clk);
        #1;
        myQValue  = randomWord();
        myEnergy  = randomWord();
        lowE      = low;
        iHaveData = 1'b1;
        @(posedge clk);
        #1;
        iHaveData = 1'b0;
    endtask

    task automatic waitDrain();
        while (expected.size() != 0) begin
            @(posedge clk);
            #1;
        end
        // last done pulse still to be seen
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic waitPacket(input pktType_e kind);
        int target;
        target = acceptCount + 1;
        while (acceptCount < target) begin
            @(posedge clk);
            #1;
        end
        compareField("rPacketType", lastType, kind);
    endtask

    initial begin : watchdog
        #((numEvents * 40 + 200) * clkPeriod);
        abortRun("timeout, the radio never finished taking the expected packets");
    end

    initial begin : tests
        nrst           = 1'b0;
        en             = 1'b0;
        iHaveData      = 1'b0;
        iAmDestination = 1'b0;
        role           = 1'b0;
        lowE           = 1'b0;
        okToSend       = 1'b0;
        fPacketType    = NONE;
        fSourceId      = '0;
        fSourceHops    = '0;
        fQValue        = '0;
        fEnergyLeft    = '0;
        fHopsFromCh    = '0;
        fChosenCh      = '0;
        myNodeId       = randomWord();
        myEnergy       = randomWord();
        myQValue       = randomWord();
        hopsFromSink   = 16'd3;
        hopsFromCh     = 16'd2;
        chosenCh       = randomWord();
        chosenHop      = randomWord();
        timeslot       = randomWord();
        repeat (8) @(posedge clk);
        #1;
        nrst = 1'b1;

        // six packets for five slots while the radio is busy
        repeat (6) ownData(1'b0);
        repeat (3) @(posedge clk);
        #1;
        okToSend = 1'b1;
        waitDrain();
        compareField("overflow", overflow, 1'b1);

        // first heartbeat ripples and the second is locked out
        receive(HB, randomWord(), 1'b0);
        receive(HB, randomWord(), 1'b0);
        waitDrain();

        // invitation below the limit then at it
        receive(INV, randomWord() % `MAX_INV_HOPS, 1'b0);
        receive(INV, `MAX_INV_HOPS, 1'b0);
        waitDrain();

        // forwarding then own data
        receive(SOS, randomWord(), 1'b1);
        receive(DATA, randomWord(), 1'b0);
        hopsFromSink = 16'd1;
        ownData(1'b1);
        hopsFromSink = 16'd3;
        ownData(1'b0);
        waitDrain();

        // idle while locked as member with a one-hop head
        role       = 1'b0;
        hopsFromCh = 16'd1;
        // first MR may already be on its way with the old hop count
        waitPacket(MR);
        waitPacket(MR);
        // distant head needs four-hop
        hopsFromCh = 16'd3;
        waitPacket(MR);
        role     = 1'b1;
        timeslot = randomWord();
        waitPacket(CHT);
        role = 1'b0;

        // forwarded data unlocks heartbeat again
        receive(DATA, randomWord(), 1'b1);
        receive(HB, randomWord(), 1'b0);
        receive(DATA, randomWord(), 1'b1);
        waitDrain();

        // lock clear so nothing else may show up
        repeat (`TIMEOUT_RELOAD + 5) @(posedge clk);
        #1;
        assert (expected.size() == 0 && txValid === 1'b0) else begin
            abortRun("a packet showed up after the last event");
        end
        compareField("overflow", overflow, expOverflow);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/rewardTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "reward_defs.svh"

module rewardTop (
    input  wire                          clk,
    input  wire                          nrst,
    // event strobes and node status
    input  wire                          en,
    input  wire                          iHaveData,
    input  wire                          iAmDestination,
    input  wire                          role,
    input  wire                          lowE,
    // received packet
    input  wire rewardPkg::pktType_e     fPacketType,
    input  wire [`WORD_WIDTH-1:0]        fSourceId,
    input  wire [`WORD_WIDTH-1:0]        fSourceHops,
    input  wire [`WORD_WIDTH-1:0]        fQValue,
    input  wire [`WORD_WIDTH-1:0]        fEnergyLeft,
    input  wire [`WORD_WIDTH-1:0]        fHopsFromCh,
    input  wire [`WORD_WIDTH-1:0]        fChosenCh,
    // own node state
    input  wire [`WORD_WIDTH-1:0]        myNodeId,
    input  wire [`WORD_WIDTH-1:0]        myEnergy,
    input  wire [`WORD_WIDTH-1:0]        myQValue,
    input  wire [`WORD_WIDTH-1:0]        hopsFromSink,
    input  wire [`WORD_WIDTH-1:0]        hopsFromCh,
    input  wire [`WORD_WIDTH-1:0]        chosenCh,
    input  wire [`WORD_WIDTH-1:0]        chosenHop,
    input  wire [`WORD_WIDTH-1:0]        timeslot,
    // radio side
    input  wire                          okToSend,
    output logic                         txValid,
    output logic                         txSetting,
    output logic                         rewardDone,
    output rewardPkg::pktType_e          rPacketType,
    output logic [`WORD_WIDTH-1:0]       rSourceId,
    output logic [`WORD_WIDTH-1:0]       rSourceHops,
    output logic [`WORD_WIDTH-1:0]       rQValue,
    output logic [`WORD_WIDTH-1:0]       rEnergyLeft,
    output logic [`WORD_WIDTH-1:0]       rDestinationId,
    output logic [`WORD_WIDTH-1:0]       rChosenCh,
    output logic [`WORD_WIDTH-1:0]       rHopsFromCh,
    output logic [`WORD_WIDTH-1:0]       rTimeslot,
    // a packet was lost to a full queue
    output logic                         overflow
);

    // trigger to queue
    logic                         pktValid;
    rewardPkg::rewardPacket_t     pkt;
    // queue to tx stage
    rewardPkg::rewardPacket_t     headPkt;
    logic                         notEmpty;
    logic                         pop;

    rewardTrigger trigger_i (
        .clk            (clk),
        .nrst           (nrst),
        .en             (en),
        .iHaveData      (iHaveData),
        .iAmDestination (iAmDestination),
        .role           (role),
        .lowE           (lowE),
        .fPacketType    (fPacketType),
        .fSourceId      (fSourceId),
        .fSourceHops    (fSourceHops),
        .fQValue        (fQValue),
        .fEnergyLeft    (fEnergyLeft),
        .fHopsFromCh    (fHopsFromCh),
        .fChosenCh      (fChosenCh),
        .myNodeId       (myNodeId),
        .myEnergy       (myEnergy),
        .myQValue       (myQValue),
        .hopsFromSink   (hopsFromSink),
        .hopsFromCh     (hopsFromCh),
        .chosenCh       (chosenCh),
        .chosenHop      (chosenHop),
        .timeslot       (timeslot),
        .pktValid       (pktValid),
        .pkt            (pkt)
    );

    // drops on full happen inside the queue
    packetQueue #(
        .depth (`QUEUE_DEPTH)
    ) queue_i (
        .clk      (clk),
        .nrst     (nrst),
        .push     (pktValid),
        .pushPkt  (pkt),
        .pop      (pop),
        .headPkt  (headPkt),
        .notEmpty (notEmpty),
        .full     (),
        .overflow (overflow)
    );

    txStage tx_i (
        .clk            (clk),
        .nrst           (nrst),
        .headPkt        (headPkt),
        .notEmpty       (notEmpty),
        .okToSend       (okToSend),
        .pop            (pop),
        .txValid        (txValid),
        .txSetting      (txSetting),
        .rewardDone     (rewardDone),
        .rPacketType    (rPacketType),
        .rSourceId      (rSourceId),
        .rSourceHops    (rSourceHops),
        .rQValue        (rQValue),
        .rEnergyLeft    (rEnergyLeft),
        .rDestinationId (rDestinationId),
        .rChosenCh      (rChosenCh),
        .rHopsFromCh    (rHopsFromCh),
        .rTimeslot      (rTimeslot)
    );

endmodule

`default_nettype wire

//--- hdl/txStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "reward_defs.svh"

module txStage (
    input  wire                          clk,
    input  wire                          nrst,
    input  wire rewardPkg::rewardPacket_t headPkt,
    input  wire                          notEmpty,
    input  wire                          okToSend,
    output logic                         pop,
    output logic                         txValid,
    output logic                         txSetting,
    output logic                         rewardDone,
    output rewardPkg::pktType_e          rPacketType,
    output logic [`WORD_WIDTH-1:0]       rSourceId,
    output logic [`WORD_WIDTH-1:0]       rSourceHops,
    output logic [`WORD_WIDTH-1:0]       rQValue,
    output logic [`WORD_WIDTH-1:0]       rEnergyLeft,
    output logic [`WORD_WIDTH-1:0]       rDestinationId,
    output logic [`WORD_WIDTH-1:0]       rChosenCh,
    output logic [`WORD_WIDTH-1:0]       rHopsFromCh,
    output logic [`WORD_WIDTH-1:0]       rTimeslot
);

    import rewardPkg::*;

    localparam logic [`WORD_WIDTH-1:0] oneWord = 1;

    // radio takes the packet at this edge
    logic accept;

    assign accept = txValid && okToSend;
    // refill when empty or on the accepting edge
    assign pop    = notEmpty && (!txValid || accept);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            txValid     <= 1'b0;
            txSetting   <= 1'b0;
            rewardDone  <= 1'b0;
            rPacketType <= NONE;
        end else begin
            // one cycle after acceptance
            rewardDone <= accept;
            if (pop) begin
                txValid     <= 1'b1;
                rPacketType <= headPkt.pktType;
                // four-hop only for MR to a distant head
                txSetting   <= (headPkt.pktType == MR) && (headPkt.hopsFromCh > oneWord);
            end else if (accept) begin
                txValid <= 1'b0;
            end
        end
    end

    // held fields, stable while txValid waits for okToSend
    always_ff @(posedge clk) begin
        if (pop) begin
            rSourceId      <= headPkt.sourceId;
            rSourceHops    <= headPkt.sourceHops;
            rQValue        <= headPkt.qValue;
            rEnergyLeft    <= headPkt.energyLeft;
            rDestinationId <= headPkt.destinationId;
            rChosenCh      <= headPkt.chosenCh;
            rHopsFromCh    <= headPkt.hopsFromCh;
            rTimeslot      <= headPkt.timeslot;
        end
    end

endmodule

`default_nettype wire

//--- hdl/packetQueue.sv
`timescale 1ns/1ps
`default_nettype none

`include "reward_defs.svh"

module packetQueue #(
    parameter int depth = `QUEUE_DEPTH
) (
    input  wire                          clk,
    input  wire                          nrst,
    input  wire                          push,
    input  wire rewardPkg::rewardPacket_t pushPkt,
    input  wire                          pop,
    output rewardPkg::rewardPacket_t     headPkt,
    output logic                         notEmpty,
    output logic                         full,
    output logic                         overflow
);

    import rewardPkg::*;

    localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntWidth = $clog2(depth + 1);
    localparam logic [ptrWidth-1:0] lastSlot = ptrWidth'(depth - 1);
    localparam logic [cntWidth-1:0] maxCount = cntWidth'(depth);

    // packet storage
    rewardPacket_t          mem [depth];
    logic [ptrWidth-1:0]    wrPtr;
    logic [ptrWidth-1:0]    rdPtr;
    logic [cntWidth-1:0]    count;
    logic                   pushOk;
    logic                   popOk;

    assign notEmpty = (count != '0);
    assign full     = (count == maxCount);
    // push while full is dropped
    assign pushOk   = push && !full;
    assign popOk    = pop && notEmpty;
    assign headPkt  = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (pushOk) begin
            mem[wrPtr] <= pushPkt;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            // pointers wrap at the last slot
            if (pushOk) begin
                wrPtr <= (wrPtr == lastSlot) ? '0 : wrPtr + 1'b1;
            end
            if (popOk) begin
                rdPtr <= (rdPtr == lastSlot) ? '0 : rdPtr + 1'b1;
            end
            // occupancy, unchanged on push with pop
            case ({pushOk, popOk})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // sticky until reset
            if (push && full) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/rewardTrigger.sv
`timescale 1ns/1ps
`default_nettype none

`include "reward_defs.svh"

module rewardTrigger (
    input  wire                          clk,
    input  wire                          nrst,
    // event strobes and node status
    input  wire                          en,
    input  wire                          iHaveData,
    input  wire                          iAmDestination,
    input  wire                          role,
    input  wire                          lowE,
    // fields of the received packet
    input  wire rewardPkg::pktType_e     fPacketType,
    input  wire [`WORD_WIDTH-1:0]        fSourceId,
    input  wire [`WORD_WIDTH-1:0]        fSourceHops,
    input  wire [`WORD_WIDTH-1:0]        fQValue,
    input  wire [`WORD_WIDTH-1:0]        fEnergyLeft,
    input  wire [`WORD_WIDTH-1:0]        fHopsFromCh,
    input  wire [`WORD_WIDTH-1:0]        fChosenCh,
    // own node state
    input  wire [`WORD_WIDTH-1:0]        myNodeId,
    input  wire [`WORD_WIDTH-1:0]        myEnergy,
    input  wire [`WORD_WIDTH-1:0]        myQValue,
    input  wire [`WORD_WIDTH-1:0]        hopsFromSink,
    input  wire [`WORD_WIDTH-1:0]        hopsFromCh,
    input  wire [`WORD_WIDTH-1:0]        chosenCh,
    input  wire [`WORD_WIDTH-1:0]        chosenHop,
    input  wire [`WORD_WIDTH-1:0]        timeslot,
    // one strobe per built packet
    output logic                         pktValid,
    output rewardPkg::rewardPacket_t     pkt
);

    import rewardPkg::*;

    localparam logic [`WORD_WIDTH-1:0] invHopLimit   = `MAX_INV_HOPS;
    localparam logic [`WORD_WIDTH-1:0] timeoutReload = `TIMEOUT_RELOAD;
    localparam logic [`WORD_WIDTH-1:0] broadcastId   = `BROADCAST_ID;
    localparam logic [`WORD_WIDTH-1:0] oneWord       = 1;

    // heartbeat ripple lock, set by first HB
    logic                    hbLock;
    logic                    lockNext;
    logic [`WORD_WIDTH-1:0]  timeoutCnt;
    logic [`WORD_WIDTH-1:0]  timeoutNext;
    logic                    timeoutZero;
    // templates the rules start from
    logic                    buildValid;
    rewardPacket_t           rxPkt;
    rewardPacket_t           ownPkt;
    rewardPacket_t           buildPkt;

    assign timeoutZero = (timeoutCnt == '0);

    // received packet fields, sent on toward chosenHop by default
    always_comb begin
        rxPkt.pktType       = fPacketType;
        rxPkt.sourceId      = fSourceId;
        rxPkt.sourceHops    = fSourceHops;
        rxPkt.qValue        = fQValue;
        rxPkt.energyLeft    = fEnergyLeft;
        rxPkt.destinationId = chosenHop;
        rxPkt.chosenCh      = fChosenCh;
        rxPkt.hopsFromCh    = fHopsFromCh;
        rxPkt.timeslot      = timeslot;
    end

    // own node fields
    // used for own data, MR and CHT
    always_comb begin
        ownPkt.pktType       = DATA;
        ownPkt.sourceId      = myNodeId;
        ownPkt.sourceHops    = hopsFromSink;
        ownPkt.qValue        = myQValue;
        ownPkt.energyLeft    = myEnergy;
        ownPkt.destinationId = chosenHop;
        ownPkt.chosenCh      = chosenCh;
        ownPkt.hopsFromCh    = hopsFromCh;
        ownPkt.timeslot      = timeslot;
    end

    // prioritized event rules
    // received packet, then own data, then timeout
    always_comb begin
        buildValid = 1'b0;
        buildPkt   = rxPkt;
        lockNext   = hbLock;
        if (en) begin
            case (fPacketType)
                HB: begin
                    // ripple only the first heartbeat
                    if (!hbLock) begin
                        buildValid             = 1'b1;
                        buildPkt.sourceHops    = hopsFromSink + oneWord;
                        buildPkt.destinationId = broadcastId;
                        lockNext               = 1'b1;
                    end
                end
                INV: begin
                    if (fHopsFromCh < invHopLimit) begin
                        buildValid             = 1'b1;
                        buildPkt.hopsFromCh    = fHopsFromCh + oneWord;
                        buildPkt.destinationId = broadcastId;
                    end
                end
                DATA, SOS: begin
                    // forward only what is addressed to this node
                    if (iAmDestination) begin
                        buildValid = 1'b1;
                        if (fPacketType == DATA) begin
                            lockNext = 1'b0;
                        end
                    end
                end
                default: begin
                    buildValid = 1'b0;
                end
            endcase
        end else if (iHaveData) begin
            buildValid       = 1'b1;
            buildPkt         = ownPkt;
            buildPkt.pktType = lowE ? SOS : DATA;
            // neighbor of the sink reports no cluster head
            if (hopsFromSink == oneWord) begin
                buildPkt.chosenCh = '0;
            end
        end else if (timeoutZero) begin
            buildValid = 1'b1;
            buildPkt   = ownPkt;
            if (role) begin
                // cluster head hands out timeslots
                buildPkt.pktType       = CHT;
                buildPkt.destinationId = broadcastId;
            end else begin
                // member asks to join its chosen head
                buildPkt.pktType       = MR;
                buildPkt.destinationId = chosenCh;
            end
        end
    end

    // idle countdown, only while locked
    always_comb begin
        if (en || iHaveData || timeoutZero) begin
            timeoutNext = timeoutReload;
        end else if (hbLock) begin
            timeoutNext = timeoutCnt - oneWord;
        end else begin
            timeoutNext = timeoutCnt;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pktValid   <= 1'b0;
            hbLock     <= 1'b0;
            timeoutCnt <= timeoutReload;
        end else begin
            pktValid   <= buildValid;
            hbLock     <= lockNext;
            timeoutCnt <= timeoutNext;
        end
    end

    // packet payload, meaningful only with pktValid
    always_ff @(posedge clk) begin
        if (buildValid) begin
            pkt <= buildPkt;
        end
    end

endmodule

`default_nettype wire

//--- hdl/rewardPkg.sv
`default_nettype none

`include "reward_defs.svh"

package rewardPkg;

    // on-air packet kinds
    // encoding matches the packet filter upstream
    typedef enum logic [2:0] {
        HB   = 3'd0,
        CHE  = 3'd1,
        INV  = 3'd2,
        MR   = 3'd3,
        CHT  = 3'd4,
        DATA = 3'd5,
        SOS  = 3'd6,
        NONE = 3'd7
    } pktType_e;

    // one built packet, stored as a single queue word
    // 3 type bits plus eight word fields
    typedef struct packed {
        pktType_e                pktType;
        // originator of the packet
        logic [`WORD_WIDTH-1:0]  sourceId;
        // sender hops from the sink
        logic [`WORD_WIDTH-1:0]  sourceHops;
        logic [`WORD_WIDTH-1:0]  qValue;
        logic [`WORD_WIDTH-1:0]  energyLeft;
        // next hop, cluster head or broadcast
        logic [`WORD_WIDTH-1:0]  destinationId;
        logic [`WORD_WIDTH-1:0]  chosenCh;
        // hops from the cluster head
        logic [`WORD_WIDTH-1:0]  hopsFromCh;
        logic [`WORD_WIDTH-1:0]  timeslot;
    } rewardPacket_t;

endpackage

`default_nettype wire

//--- hdl/reward_defs.svh
`ifndef REWARD_DEFS_SVH
`define REWARD_DEFS_SVH

// width of every id, hop, energy, q-value and timeslot field
`define WORD_WIDTH 16

// idle cycles counted before a timeout event fires
`define TIMEOUT_RELOAD 10

// invitations ripple only while their hop count stays below this
`define MAX_INV_HOPS 4

// entries in the built-packet queue
`define QUEUE_DEPTH 4

// destination for broadcast packets
// (heartbeat, invitation and cluster-head timeslot)
`define BROADCAST_ID 16'hFFFF

`endif
